//--- logic/hostPkg.sv
`default_nettype none

package hostPkg;

  // word addresses on the host bus
  typedef enum logic [2:0] {
    regCtrl   = 3'd0, // write starts a job
    regXWin   = 3'd1, // xStart in [31:16], xEnd in [15:0]
    regYWin   = 3'd2, // yStart in [31:16], yEnd in [15:0]
    regColor  = 3'd3, // rgb565 in [15:0]
    regStatus = 3'd4  // busy in [0], done count in [15:8]
  } regAddrT;

  typedef enum logic [1:0] {
    jobInit,
    jobDispOn,
    jobDispOff,
    jobFill
  } jobOpT;

  typedef struct packed {
    jobOpT       op;
    logic [15:0] xStart;
    logic [15:0] xEnd;
    logic [15:0] yStart;
    logic [15:0] yEnd;
    logic [15:0] color;
  } jobT;

endpackage

`default_nettype wire

//--- logic/dbiPkg.sv
`default_nettype none

package dbiPkg;

  // panel command bytes
  typedef enum logic [7:0] {
    cmdSwReset  = 8'h01,
    cmdSleepIn  = 8'h10,
    cmdSleepOut = 8'h11,
    cmdDispOff  = 8'h28,
    cmdDispOn   = 8'h29,
    cmdColSet   = 8'h2A,
    cmdPageSet  = 8'h2B,
    cmdMemWrite = 8'h2C,
    cmdMadCtl   = 8'h36,
    cmdPixFmt   = 8'h3A
  } dbiCmdT;

  localparam logic [7:0] pixFmtParam = 8'h55; // 16 bit per pixel
  localparam logic [7:0] madCtlParam = 8'hB8; // row/col exchange, bgr

  typedef enum logic [1:0] {
    beatCmd,
    beatParam,
    beatWait,
    beatEnd
  } beatKindT;

  typedef enum logic [1:0] {
    waitReset,
    waitSleepIn,
    waitSleepOut
  } waitSelT;

  typedef struct packed {
    beatKindT   kind;
    logic [7:0] data;
    waitSelT    waitSel;
  } beatT;

endpackage

`default_nettype wire

//--- logic/wbRegs.sv
`default_nettype none

module wbRegs import hostPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        wbCyc,
  input  logic        wbStb,
  input  logic        wbWe,
  input  regAddrT     wbAdr,
  input  logic [31:0] wbDatW,
  output logic [31:0] wbDatR,
  output logic        wbAck,
  output logic        jobValid,
  output jobT         job,
  input  logic        jobReady,
  input  logic        jobDone
);

  logic [31:0] xWin;
  logic [31:0] yWin;
  logic [15:0] color;
  logic        busy;
  logic [7:0]  doneCount;
  logic        request;
  logic        ctrlWrite;
  logic        serve;

  assign request   = wbCyc && wbStb && !wbAck;
  assign ctrlWrite = wbWe && (wbAdr == regCtrl);

  // a job write stalls until the sequencer is idle
  assign jobValid = request && ctrlWrite;
  assign serve    = request && (!ctrlWrite || jobReady);

  always_comb begin
    job.op     = jobOpT'(wbDatW[1:0]);
    job.xStart = xWin[31:16];
    job.xEnd   = xWin[15:0];
    job.yStart = yWin[31:16];
    job.yEnd   = yWin[15:0];
    job.color  = color;
  end

  always_comb begin
    case (wbAdr)
      regXWin:   wbDatR = xWin;
      regYWin:   wbDatR = yWin;
      regColor:  wbDatR = {16'h0000, color};
      regStatus: wbDatR = {16'h0000, doneCount, 7'b0000000, busy};
      default:   wbDatR = 32'h0000_0000;
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wbAck     <= 1'b0;
      busy      <= 1'b0;
      doneCount <= 8'd0;
    end else begin
      wbAck <= serve;
      if (jobValid && jobReady) begin
        busy <= 1'b1;
      end else if (jobDone) begin
        busy <= 1'b0;
      end
      if (jobDone) begin
        doneCount <= doneCount + 8'd1; // wraps
      end
    end
  end

  always_ff @(posedge clk) begin
    if (serve && wbWe) begin
      case (wbAdr)
        regXWin:  xWin <= wbDatW;
        regYWin:  yWin <= wbDatW;
        regColor: color <= wbDatW[15:0];
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/displaySequencer.sv
`default_nettype none

module displaySequencer import hostPkg::*, dbiPkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic jobValid,
  input  jobT  job,
  output logic jobReady,
  output logic jobDone,
  output logic beatValid,
  output beatT beat,
  input  logic beatReady
);

  typedef enum logic [2:0] {
    stIdle,
    stHeader, // fixed command list of the job
    stPixHi,
    stPixLo,
    stEnd
  } stateT;

  stateT       state;
  jobT         curJob;
  logic [3:0]  step;
  logic [33:0] pixLeft;
  logic [16:0] spanX;
  logic [16:0] spanY;
  logic [33:0] pixTotal;
  logic        take;

  function automatic beatT cmdBeat(input dbiCmdT c);
    return '{kind: beatCmd, data: c, waitSel: waitReset};
  endfunction

  function automatic beatT parBeat(input logic [7:0] d);
    return '{kind: beatParam, data: d, waitSel: waitReset};
  endfunction

  function automatic beatT waitBeat(input waitSelT w);
    return '{kind: beatWait, data: 8'h00, waitSel: w};
  endfunction

  function automatic logic [3:0] lastStep(input jobOpT op);
    case (op)
      jobInit:   return 4'd8;
      jobDispOn: return 4'd2;
      jobDispOff: return 4'd2;
      default:   return 4'd10;
    endcase
  endfunction

  function automatic beatT headerBeat(input jobT j, input logic [3:0] idx);
    beatT b;
    b = cmdBeat(cmdDispOn);
    case (j.op)
      jobInit: begin
        case (idx)
          4'd0: b = cmdBeat(cmdSwReset);
          4'd1: b = waitBeat(waitReset);
          4'd2: b = cmdBeat(cmdSleepOut);
          4'd3: b = waitBeat(waitSleepOut);
          4'd4: b = cmdBeat(cmdPixFmt);
          4'd5: b = parBeat(pixFmtParam);
          4'd6: b = cmdBeat(cmdMadCtl);
          4'd7: b = parBeat(madCtlParam);
          default: b = cmdBeat(cmdDispOn);
        endcase
      end
      jobDispOn: begin
        case (idx)
          4'd0: b = cmdBeat(cmdSleepOut);
          4'd1: b = waitBeat(waitSleepOut);
          default: b = cmdBeat(cmdDispOn);
        endcase
      end
      jobDispOff: begin
        case (idx)
          4'd0: b = cmdBeat(cmdDispOff);
          4'd1: b = cmdBeat(cmdSleepIn);
          default: b = waitBeat(waitSleepIn);
        endcase
      end
      default: begin
        case (idx)
          4'd0: b = cmdBeat(cmdColSet);
          4'd1: b = parBeat(j.xStart[15:8]);
          4'd2: b = parBeat(j.xStart[7:0]);
          4'd3: b = parBeat(j.xEnd[15:8]);
          4'd4: b = parBeat(j.xEnd[7:0]);
          4'd5: b = cmdBeat(cmdPageSet);
          4'd6: b = parBeat(j.yStart[15:8]);
          4'd7: b = parBeat(j.yStart[7:0]);
          4'd8: b = parBeat(j.yEnd[15:8]);
          4'd9: b = parBeat(j.yEnd[7:0]);
          default: b = cmdBeat(cmdMemWrite);
        endcase
      end
    endcase
    return b;
  endfunction

  // pixel count of the incoming window, empty if inverted
  always_comb begin
    spanX = (job.xEnd >= job.xStart) ? ({1'b0, job.xEnd} - {1'b0, job.xStart} + 17'd1) : 17'd0;
    spanY = (job.yEnd >= job.yStart) ? ({1'b0, job.yEnd} - {1'b0, job.yStart} + 17'd1) : 17'd0;
    pixTotal = spanX * spanY;
  end

  assign jobReady  = (state == stIdle);
  assign beatValid = (state != stIdle);
  assign take      = beatValid && beatReady;
  assign jobDone   = (state == stEnd) && beatReady;

  always_comb begin
    case (state)
      stHeader: beat = headerBeat(curJob, step);
      stPixHi:  beat = parBeat(curJob.color[15:8]);
      stPixLo:  beat = parBeat(curJob.color[7:0]);
      default:  beat = '{kind: beatEnd, data: 8'h00, waitSel: waitReset};
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state   <= stIdle;
      step    <= 4'd0;
      pixLeft <= '0;
    end else begin
      case (state)
        stIdle: begin
          if (jobValid) begin
            step    <= 4'd0;
            pixLeft <= pixTotal;
            state   <= stHeader;
          end
        end
        stHeader: begin
          if (take) begin
            if (step != lastStep(curJob.op)) begin
              step <= step + 4'd1;
            end else if (curJob.op == jobFill && pixLeft != '0) begin
              state <= stPixHi;
            end else begin
              state <= stEnd;
            end
          end
        end
        stPixHi: begin
          if (take) state <= stPixLo;
        end
        stPixLo: begin
          if (take) begin
            pixLeft <= pixLeft - 34'd1;
            state   <= (pixLeft == 34'd1) ? stEnd : stPixHi;
          end
        end
        default: begin
          if (take) state <= stIdle; // end beat consumed
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == stIdle && jobValid) begin
      curJob <= job;
    end
  end

endmodule

`default_nettype wire

//--- logic/dbiWriter.sv
`default_nettype none

module dbiWriter import dbiPkg::*; #(
  parameter int resetWaitCycles    = 120000,
  parameter int sleepOutWaitCycles = 600000,
  parameter int sleepInWaitCycles  = 250000
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       beatValid,
  input  beatT       beat,
  output logic       beatReady,
  output logic       csx,
  output logic       dcx,
  output logic       wrx,
  output logic [7:0] data
);

  typedef enum logic [1:0] {
    phReady,
    phStrobe, // wrx low with data on the bus
    phWait
  } phaseT;

  phaseT       phase;
  logic [31:0] waitCnt;
  logic [31:0] waitLoad;

  // first beat of a job only opens csx
  assign beatReady = (phase == phReady) && !csx;

  always_comb begin
    case (beat.waitSel)
      waitSleepIn:  waitLoad = 32'(sleepInWaitCycles);
      waitSleepOut: waitLoad = 32'(sleepOutWaitCycles);
      default:      waitLoad = 32'(resetWaitCycles);
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      phase   <= phReady;
      csx     <= 1'b1;
      dcx     <= 1'b1;
      wrx     <= 1'b1;
      data    <= 8'h00;
      waitCnt <= 32'd0;
    end else begin
      case (phase)
        phReady: begin
          if (beatValid && csx) begin
            csx <= 1'b0;
          end else if (beatValid) begin
            case (beat.kind)
              beatCmd, beatParam: begin
                wrx   <= 1'b0;
                dcx   <= (beat.kind == beatParam);
                data  <= beat.data;
                phase <= phStrobe;
              end
              beatWait: begin
                waitCnt <= waitLoad;
                phase   <= phWait;
              end
              default: csx <= 1'b1; // end of job
            endcase
          end
        end
        phStrobe: begin
          wrx   <= 1'b1; // panel latches here
          phase <= phReady;
        end
        default: begin
          waitCnt <= waitCnt - 32'd1;
          if (waitCnt <= 32'd1) phase <= phReady;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/displayCtrl.sv
`default_nettype none

module displayCtrl import hostPkg::*, dbiPkg::*; #(
  parameter int resetWaitCycles    = 120000,
  parameter int sleepOutWaitCycles = 600000,
  parameter int sleepInWaitCycles  = 250000
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        wbCyc,
  input  logic        wbStb,
  input  logic        wbWe,
  input  regAddrT     wbAdr,
  input  logic [31:0] wbDatW,
  output logic [31:0] wbDatR,
  output logic        wbAck,
  output logic        csx,
  output logic        dcx,
  output logic        wrx,
  output logic [7:0]  data
);

  logic jobValid;
  logic jobReady;
  logic jobDone;
  jobT  job;
  logic beatValid;
  logic beatReady;
  beatT beat;

  wbRegs regs (
    .clk, .rst,
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
    .jobValid, .job, .jobReady, .jobDone
  );

  displaySequencer sequencer (
    .clk, .rst,
    .jobValid, .job, .jobReady, .jobDone,
    .beatValid, .beat, .beatReady
  );

  dbiWriter #(
    .resetWaitCycles(resetWaitCycles),
    .sleepOutWaitCycles(sleepOutWaitCycles),
    .sleepInWaitCycles(sleepInWaitCycles)
  ) writer (
    .clk, .rst,
    .beatValid, .beat, .beatReady,
    .csx, .dcx, .wrx, .data
  );

endmodule

`default_nettype wire

//--- tests/dbiMonitor.sv
`default_nettype none

module dbiMonitor import dbiPkg::*; #(
  parameter int resetWaitCycles = 40
) (
  input logic       clk,
  input logic       rst,
  input logic       csx,
  input logic       dcx,
  input logic       wrx,
  input logic [7:0] data
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [8:0] expQ[$]; // {dcx, data} in bus order
  logic [8:0] seenByte;
  logic [8:0] wantByte;
  int         bytesSeen = 0;
  int         byteErrors = 0;
  int         valueErrors = 0;
  int         otherErrors = 0;
  int         endCount = 0; // csx rising edges, one per finished job
  longint     cycleCount = 0;
  longint     swResetCycle = 0;
  logic       gapOpen = 1'b0;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
  end

  always @(posedge csx) begin
    if (!rst) endCount++;
  end

  // panel latches on the rising wrx edge
  always @(posedge wrx) begin
    if (!rst && !csx) begin
      seenByte = {dcx, data};
      bytesSeen++;
      if (expQ.size() == 0) begin
        $display("unexpected byte %h with dcx %b on the panel bus at %0t ns", data, dcx, $time);
        otherErrors++;
      end else begin
        wantByte = expQ.pop_front();
        if (seenByte !== wantByte) begin
          $display("error at %0t ns: dcx/data is %b/%h, expected %b/%h",
                   $time, dcx, data, wantByte[8], wantByte[7:0]);
          byteErrors++;
        end
      end
      if (seenByte == {1'b0, cmdSwReset}) begin
        swResetCycle = cycleCount;
        gapOpen      = 1'b1;
      end else if (gapOpen && seenByte == {1'b0, cmdSleepOut}) begin
        gapOpen = 1'b0;
        if (cycleCount - swResetCycle < resetWaitCycles) begin
          $display("error at %0t ns: reset wait is %0d clocks, expected at least %0d",
                   $time, cycleCount - swResetCycle, resetWaitCycles);
          valueErrors++;
        end
      end
    end
  end

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, want);
      valueErrors++;
    end
  endtask

  task automatic reportFailure(input string what);
    $display("%s (at %0t ns)", what, $time);
    otherErrors++;
  endtask

  task automatic checkDrained(input string jobName);
    if (expQ.size() != 0) begin
      $display("%s job ended with %0d expected bytes never strobed", jobName, expQ.size());
      otherErrors++;
      expQ.delete();
    end
  endtask

  function automatic int errorTotal();
    return byteErrors + valueErrors + otherErrors;
  endfunction

  task automatic finalReport();
    if (expQ.size() != 0) begin
      $display("%0d expected bytes were never strobed on the panel bus", expQ.size());
      otherErrors++;
    end
    $display("panel bytes %0d, byte errors %0d, value errors %0d, other errors %0d",
             bytesSeen, byteErrors, valueErrors, otherErrors);
  endtask

endmodule

`default_nettype wire

//--- tests/displayCtrl_props.sv
`default_nettype none

module displayCtrlProps (
  input logic clk,
  input logic rst,
  input logic csx,
  input logic wrx,
  input logic wbCyc,
  input logic wbStb,
  input logic wbAck
);
  timeunit 1ns;
  timeprecision 100ps;

  wrxInsideCsx: assert property (@(posedge clk) disable iff (rst) !(csx && !wrx))
    else $error("wrx strobed while csx is high");

  // ack answers a strobe of the previous cycle
  ackInCycle: assert property (@(posedge clk) disable iff (rst)
    $rose(wbAck) |-> $past(wbCyc && wbStb))
    else $error("wbAck rose outside a Wishbone cycle");

  quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> (csx && wrx && !wbAck))
    else $error("csx, wrx or wbAck active right after reset");

endmodule

bind displayCtrl displayCtrlProps props (
  .clk(clk),
  .rst(rst),
  .csx(csx),
  .wrx(wrx),
  .wbCyc(wbCyc),
  .wbStb(wbStb),
  .wbAck(wbAck)
);

`default_nettype wire

//--- tests/displayCtrlTb.sv
`default_nettype none

module displayCtrlTb import hostPkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int clkPeriod = 4;
  localparam int resetWait = 40;
  localparam int sleepOutWait = 60;
  localparam int sleepInWait = 30;
  localparam int randFills = 5;
  localparam int fillJobs = randFills + 2; // plus inverted window and back-pressure fill
  localparam int jobCount = fillJobs + 4;
  localparam int byteCount = 7 + 2 + 2 + 2 + fillJobs * 43; // 43 bytes for a 4x4 fill
  localparam int waitCount = resetWait + 3 * sleepOutWait + sleepInWait;
  localparam int limitCycles = 2 * (2 * byteCount + waitCount + 20 * jobCount);

  logic        clk;
  logic        rst;
  logic        wbCyc;
  logic        wbStb;
  logic        wbWe;
  regAddrT     wbAdr;
  logic [31:0] wbDatW;
  logic [31:0] wbDatR;
  logic        wbAck;
  logic        csx;
  logic        dcx;
  logic        wrx;
  logic [7:0]  data;
  logic [31:0] lfsrState;
  logic [31:0] rdata;
  logic [31:0] wval;
  logic [15:0] xs, xe, ys, ye, color, hi, lo;
  int          ackWait;
  int          jobsDone;

  displayCtrl #(
    .resetWaitCycles(resetWait),
    .sleepOutWaitCycles(sleepOutWait),
    .sleepInWaitCycles(sleepInWait)
  ) DUT (
    .clk, .rst,
    .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
    .csx, .dcx, .wrx, .data
  );

  dbiMonitor #(.resetWaitCycles(resetWait)) monitor (
    .clk, .rst, .csx, .dcx, .wrx, .data
  );

  always #(clkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
  endfunction

  task automatic takeBits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      v = {v[14:0], lfsrState[0]};
    end
  endtask

  function automatic void pushCmd(input logic [7:0] b);
    monitor.expQ.push_back({1'b0, b});
  endfunction

  function automatic void pushParam(input logic [7:0] b);
    monitor.expQ.push_back({1'b1, b});
  endfunction

  function automatic void expectedBytes(input jobOpT op, input logic [15:0] x0, x1, y0, y1, c);
    int spanX;
    int spanY;
    case (op)
      jobInit: begin
        pushCmd(8'h01);
        pushCmd(8'h11);
        pushCmd(8'h3A);
        pushParam(8'h55);
        pushCmd(8'h36);
        pushParam(8'hB8);
        pushCmd(8'h29);
      end
      jobDispOn: begin
        pushCmd(8'h11);
        pushCmd(8'h29);
      end
      jobDispOff: begin
        pushCmd(8'h28);
        pushCmd(8'h10);
      end
      default: begin
        pushCmd(8'h2A);
        pushParam(x0[15:8]);
        pushParam(x0[7:0]);
        pushParam(x1[15:8]);
        pushParam(x1[7:0]);
        pushCmd(8'h2B);
        pushParam(y0[15:8]);
        pushParam(y0[7:0]);
        pushParam(y1[15:8]);
        pushParam(y1[7:0]);
        pushCmd(8'h2C);
        spanX = (x1 >= x0) ? int'(x1) - int'(x0) + 1 : 0; // inverted window is empty
        spanY = (y1 >= y0) ? int'(y1) - int'(y0) + 1 : 0;
        repeat (spanX * spanY) begin
          pushParam(c[15:8]);
          pushParam(c[7:0]);
        end
      end
    endcase
  endfunction

  task automatic writeReg(input regAddrT adr, input logic [31:0] dat);
    @(posedge clk);
    #1;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = 1'b1;
    wbAdr = adr;
    wbDatW = dat;
    ackWait = 0;
    do begin
      @(posedge clk);
      #1;
      ackWait++;
    end while (!wbAck);
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
  endtask

  task automatic readReg(input regAddrT adr, output logic [31:0] dat);
    @(posedge clk);
    #1;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe = 1'b0;
    wbAdr = adr;
    do begin
      @(posedge clk);
      #1;
    end while (!wbAck);
    dat = wbDatR;
    wbCyc = 1'b0;
    wbStb = 1'b0;
  endtask

  task automatic waitIdle(output logic [31:0] status);
    do begin
      readReg(regStatus, status);
    end while (status[0]);
  endtask

  task automatic randomWindow(output logic [15:0] x0, x1, y0, y1, c);
    logic [15:0] size;
    takeBits(9, x0);
    takeBits(2, size);
    x1 = x0 + size; // 1 to 4 pixels wide
    takeBits(9, y0);
    takeBits(2, size);
    y1 = y0 + size;
    takeBits(16, c);
  endtask

  task automatic loadWindow(input logic [15:0] x0, x1, y0, y1, c);
    writeReg(regXWin, {x0, x1});
    writeReg(regYWin, {y0, y1});
    writeReg(regColor, {16'h0000, c});
  endtask

  task automatic runJob(input jobOpT op, input logic [15:0] x0, x1, y0, y1, c, input string name);
    int          ends;
    logic [31:0] status;
    if (op == jobFill) loadWindow(x0, x1, y0, y1, c);
    ends = monitor.endCount;
    expectedBytes(op, x0, x1, y0, y1, c);
    writeReg(regCtrl, 32'(op));
    waitIdle(status);
    jobsDone++;
    monitor.checkDrained(name);
    monitor.checkValue("csx end count", monitor.endCount, ends + 1);
    monitor.checkValue("regStatus count", status[15:8], jobsDone[7:0]);
  endtask

  // second job written while a fill is still on the bus
  task automatic backPressure();
    int          ends;
    logic [31:0] status;
    logic [15:0] x0, x1, y0, y1, c;
    randomWindow(x0, x1, y0, y1, c);
    loadWindow(x0, x1, y0, y1, c);
    expectedBytes(jobFill, x0, x1, y0, y1, c);
    writeReg(regCtrl, 32'(jobFill));
    ends = monitor.endCount;
    expectedBytes(jobDispOn, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0);
    writeReg(regCtrl, 32'(jobDispOn));
    if (monitor.endCount != ends + 1) begin
      monitor.reportFailure("display on was acked before the running fill ended");
    end
    if (ackWait < 26) begin
      monitor.reportFailure("display on was acked without waiting for the fill");
    end
    waitIdle(status);
    jobsDone += 2;
    monitor.checkDrained("back-pressure");
    monitor.checkValue("csx end count", monitor.endCount, ends + 2);
    monitor.checkValue("regStatus count", status[15:8], jobsDone[7:0]);
  endtask

  initial begin
    #(limitCycles * clkPeriod);
    $display("timeout after %0d clocks, the jobs did not finish", limitCycles);
    monitor.finalReport();
    $display("Checks failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = regCtrl;
    wbDatW = 32'h0000_0000;
    lfsrState = 32'h0d7d_3be3;
    jobsDone = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    runJob(jobInit, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, "init");

    // register readback
    takeBits(16, hi);
    takeBits(16, lo);
    wval = {hi, lo};
    writeReg(regXWin, wval);
    readReg(regXWin, rdata);
    monitor.checkValue("regXWin", rdata, wval);
    takeBits(16, hi);
    wval = {lo, hi};
    writeReg(regYWin, wval);
    readReg(regYWin, rdata);
    monitor.checkValue("regYWin", rdata, wval);
    writeReg(regColor, {hi, lo});
    readReg(regColor, rdata);
    monitor.checkValue("regColor", rdata, {16'h0000, lo}); // upper half reads 0

    runJob(jobDispOff, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, "display off");
    runJob(jobDispOn, 16'd0, 16'd0, 16'd0, 16'd0, 16'd0, "display on");
    for (int i = 0; i < randFills; i++) begin
      randomWindow(xs, xe, ys, ye, color);
      runJob(jobFill, xs, xe, ys, ye, color, "fill");
    end
    runJob(jobFill, 16'd20, 16'd10, 16'd5, 16'd7, 16'hF800, "inverted fill");
    backPressure();

    monitor.finalReport();
    if (monitor.errorTotal() == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
logic/hostPkg.sv
logic/dbiPkg.sv
logic/wbRegs.sv
logic/displaySequencer.sv
logic/dbiWriter.sv
logic/displayCtrl.sv
tests/dbiMonitor.sv
tests/displayCtrl_props.sv
tests/displayCtrlTb.sv

//--- Bender.yml
package:
  name: displayCtrl

sources:
  # design sources, also pulled in by the test target
  - target: any(rtl, test)
    files:
      - logic/hostPkg.sv
      - logic/dbiPkg.sv
      - logic/wbRegs.sv
      - logic/displaySequencer.sv
      - logic/dbiWriter.sv
      - logic/displayCtrl.sv
  - target: test
    files:
      - tests/dbiMonitor.sv
      - tests/displayCtrl_props.sv
      - tests/displayCtrlTb.sv
